// ==== design/csr_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Machine-mode CSR unit shared types and constants
// Widths, CSR addresses, funct3 codes, field masks and bus structs
//////////////////////////////////////////////////////////////////////

`default_nettype none

package csr_pkg;

    // Data path width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [4:0]      zimm_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [2:0]      funct3_t;

    // Machine trap setup and handling
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MISA     = 12'h301;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    // Read-only counter halves
    localparam csr_addr_t CSR_CYCLE    = 12'hC00;
    localparam csr_addr_t CSR_TIME     = 12'hC01;
    localparam csr_addr_t CSR_CYCLEH   = 12'hC80;
    localparam csr_addr_t CSR_TIMEH    = 12'hC81;
    localparam csr_addr_t CSR_MHARTID  = 12'hF14;

    // Zicsr operation codes
    localparam funct3_t F3_CSRRW  = 3'd1;
    localparam funct3_t F3_CSRRS  = 3'd2;
    localparam funct3_t F3_CSRRC  = 3'd3;
    localparam funct3_t F3_CSRRWI = 3'd5;
    localparam funct3_t F3_CSRRSI = 3'd6;
    localparam funct3_t F3_CSRRCI = 3'd7;

    // mstatus keeps MIE (bit 3) and MPIE (bit 7) only
    localparam xlen_t MSTATUS_WMASK   = 32'h0000_0088;
    localparam int    MSTATUS_MIE_BIT = 3;

    // Interrupt bit positions, same in mie and mip
    localparam int MIP_MSIP_BIT = 3;
    localparam int MIP_MTIP_BIT = 7;
    localparam int MIP_MEIP_BIT = 11;

    // RV32I with MXL = 1
    localparam xlen_t MISA_VALUE = 32'h4000_0100;
    localparam xlen_t HART_ID    = 32'h0000_0000;

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        STORE
    } exec_state_t;

    // CSR write strobe
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        xlen_t     data;
    } csr_write_t;

    // Integer register write-back
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        xlen_t     data;
    } rd_write_t;

    typedef struct packed {
        logic ext;
        logic timer;
        logic sw;
    } irq_lines_t;

    // Registers the rest of the core looks at
    typedef struct packed {
        xlen_t mtvec;
        xlen_t mepc;
        xlen_t mstatus;
        logic  meip;
        logic  mtip;
        logic  msip;
    } csr_sideband_t;

endpackage

`default_nettype wire

// ==== design/csr_exec.sv ====
//////////////////////////////////////////////////////////////////////
// CSR execution machine
// Decodes Zicsr instructions and computes write-back and new CSR value
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module csr_exec
    import csr_pkg::*;
(
    input  wire        aclk,
    input  wire        aresetn,
    // Instruction bus
    input  wire        valid,
    output logic       ready,
    input  wire inst_t instbus,
    // rs1 register file port
    output reg_addr_t  rs1_addr,
    input  wire xlen_t rs1_val,
    // CSR file read port
    output logic       csr_rd_en,
    output csr_addr_t  csr_rd_addr,
    input  wire xlen_t old_val,
    // Write-back and CSR write strobe
    output rd_write_t  rd_wr,
    output csr_write_t csr_wr
);

    exec_state_t state;
    logic        accept;

    // Instruction fields
    funct3_t   funct3;
    reg_addr_t rs1;
    reg_addr_t rd;
    zimm_t     zimm;
    csr_addr_t csr_addr;

    // Fields held for the COMPUTE cycle
    funct3_t   funct3_r;
    reg_addr_t rs1_r;
    reg_addr_t rd_r;
    zimm_t     zimm_r;
    csr_addr_t csr_r;
    xlen_t     rs1_val_r;

    xlen_t     operand;
    xlen_t     new_val;
    logic      src_zero;
    logic      op_legal;
    logic      csr_we;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    // I-type layout with rs1 and zimm sharing bits 19:15
    assign funct3   = instbus[14:12];
    assign rs1      = instbus[19:15];
    assign rd       = instbus[11:7];
    assign zimm     = instbus[19:15];
    assign csr_addr = instbus[31:20];

    assign accept = valid && ready;

    assign rs1_addr    = rs1;
    // Old value captured by the CSR file on the acceptance edge
    assign csr_rd_en   = accept;
    assign csr_rd_addr = csr_addr;

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= IDLE;
            ready <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= COMPUTE;
                        ready <= 1'b0;
                    end else begin
                        ready <= 1'b1;
                    end
                end
                // Write-back and CSR strobe go out here
                COMPUTE: state <= STORE;
                STORE: begin
                    state <= IDLE;
                    ready <= 1'b1;
                end
                default: begin
                    state <= IDLE;
                    ready <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            funct3_r  <= funct3;
            rs1_r     <= rs1;
            rd_r      <= rd;
            zimm_r    <= zimm;
            csr_r     <= csr_addr;
            rs1_val_r <= rs1_val;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // New value
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Bit 2 selects the zero-extended immediate forms
        operand  = funct3_r[2] ? xlen_t'(zimm_r) : rs1_val_r;
        src_zero = funct3_r[2] ? (zimm_r == '0) : (rs1_r == '0);
        new_val  = operand;
        op_legal = 1'b1;
        csr_we   = 1'b1;
        case (funct3_r)
            F3_CSRRW, F3_CSRRWI: new_val = operand;
            F3_CSRRS, F3_CSRRSI: begin
                new_val = old_val | operand;
                csr_we  = !src_zero;
            end
            // Clear the mask bits
            F3_CSRRC, F3_CSRRCI: begin
                new_val = old_val & ~operand;
                csr_we  = !src_zero;
            end
            default: begin
                op_legal = 1'b0;
                csr_we   = 1'b0;
            end
        endcase
    end

    assign rd_wr = '{
        en:   (state == COMPUTE) && op_legal,
        addr: rd_r,
        data: old_val
    };

    assign csr_wr = '{
        en:   (state == COMPUTE) && csr_we,
        addr: csr_r,
        data: new_val
    };

endmodule

`default_nettype wire

// ==== design/csr_file.sv ====
//////////////////////////////////////////////////////////////////////
// Machine CSR storage, time counter and registered read port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module csr_file
    import csr_pkg::*;
(
    input  wire             aclk,
    input  wire             aresetn,
    // Read port from the execution machine
    input  wire             csr_rd_en,
    input  wire csr_addr_t  csr_rd_addr,
    output xlen_t           old_val,
    // CSR write strobe
    input  wire csr_write_t csr_wr,
    // Pending bits from the interrupt block
    input  wire xlen_t      mip,
    output logic            mstatus_mie,
    output xlen_t           mie,
    // Sideband to the core
    output csr_sideband_t   csr_sb
);

    xlen_t       mstatus;
    xlen_t       mtvec;
    xlen_t       mscratch;
    xlen_t       mepc;
    xlen_t       mcause;
    xlen_t       mtval;
    logic [63:0] time_cnt;
    xlen_t       rd_mux;

    //////////////////////////////////////////////////////////////////////
    // Writable registers
    //////////////////////////////////////////////////////////////////////

    // Each register decodes only its own address
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (csr_wr.en) begin
            case (csr_wr.addr)
                // Only MIE and MPIE stick
                CSR_MSTATUS:  mstatus  <= csr_wr.data & MSTATUS_WMASK;
                CSR_MIE:      mie      <= csr_wr.data;
                CSR_MTVEC:    mtvec    <= csr_wr.data;
                CSR_MSCRATCH: mscratch <= csr_wr.data;
                // IALIGN = 32
                CSR_MEPC:     mepc     <= {csr_wr.data[XLEN-1:2], 2'b00};
                CSR_MCAUSE:   mcause   <= csr_wr.data;
                CSR_MTVAL:    mtval    <= csr_wr.data;
                default: ;
            endcase
        end
    end

    assign mstatus_mie = mstatus[MSTATUS_MIE_BIT];

    //////////////////////////////////////////////////////////////////////
    // Time counter
    //////////////////////////////////////////////////////////////////////

    // Free-running count read by both cycle and time
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            time_cnt <= '0;
        end else begin
            time_cnt <= time_cnt + 64'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (csr_rd_addr)
            CSR_MSTATUS:  rd_mux = mstatus;
            CSR_MISA:     rd_mux = MISA_VALUE;
            CSR_MIE:      rd_mux = mie;
            CSR_MTVEC:    rd_mux = mtvec;
            CSR_MSCRATCH: rd_mux = mscratch;
            CSR_MEPC:     rd_mux = mepc;
            CSR_MCAUSE:   rd_mux = mcause;
            CSR_MTVAL:    rd_mux = mtval;
            CSR_MIP:      rd_mux = mip;
            CSR_CYCLE,
            CSR_TIME:     rd_mux = time_cnt[31:0];
            CSR_CYCLEH,
            CSR_TIMEH:    rd_mux = time_cnt[63:32];
            CSR_MHARTID:  rd_mux = HART_ID;
            // Unknown address reads zero
            default:      rd_mux = '0;
        endcase
    end

    // Sampled on the acceptance edge
    always_ff @(posedge aclk) begin
        if (csr_rd_en) begin
            old_val <= rd_mux;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sideband
    //////////////////////////////////////////////////////////////////////

    assign csr_sb = '{
        mtvec:   mtvec,
        mepc:    mepc,
        mstatus: mstatus,
        meip:    mip[MIP_MEIP_BIT],
        mtip:    mip[MIP_MTIP_BIT],
        msip:    mip[MIP_MSIP_BIT]
    };

endmodule

`default_nettype wire

// ==== design/irq_pending.sv ====
//////////////////////////////////////////////////////////////////////
// Interrupt line synchroniser and mip pending register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module irq_pending
    import csr_pkg::*;
(
    input  wire             aclk,
    input  wire             aresetn,
    // Asynchronous interrupt lines
    input  wire irq_lines_t irqs,
    // Enables from the CSR file
    input  wire             mstatus_mie,
    input  wire xlen_t      mie,
    input  wire csr_write_t csr_wr,
    output xlen_t           mip
);

    irq_lines_t irq_meta;
    irq_lines_t irq_sync;
    logic       irq_any;

    // Two flops per line
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            irq_meta <= '0;
            irq_sync <= '0;
        end else begin
            irq_meta <= irqs;
            irq_sync <= irq_meta;
        end
    end

    assign irq_any = irq_sync.ext | irq_sync.timer | irq_sync.sw;

    //////////////////////////////////////////////////////////////////////
    // Pending bits
    //////////////////////////////////////////////////////////////////////

    // Lines win over a CSR write; bits hold once all lines drop
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mip <= '0;
        end else if (irq_any) begin
            mip[MIP_MEIP_BIT] <= mstatus_mie & mie[MIP_MEIP_BIT] & irq_sync.ext;
            mip[MIP_MTIP_BIT] <= mstatus_mie & mie[MIP_MTIP_BIT] & irq_sync.timer;
            mip[MIP_MSIP_BIT] <= mstatus_mie & mie[MIP_MSIP_BIT] & irq_sync.sw;
        end else if (csr_wr.en && (csr_wr.addr == CSR_MIP)) begin
            mip <= csr_wr.data;
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_top.sv ====
//////////////////////////////////////////////////////////////////////
// Machine-mode CSR unit top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module csr_top
    import csr_pkg::*;
(
    input  wire             aclk,
    input  wire             aresetn,
    // Instruction bus
    input  wire             valid,
    output logic            ready,
    input  wire inst_t      instbus,
    // Register file ports
    output reg_addr_t       rs1_addr,
    input  wire xlen_t      rs1_val,
    output rd_write_t       rd_wr,
    // Interrupts and sideband
    input  wire irq_lines_t irqs,
    output csr_sideband_t   csr_sb
);

    logic       csr_rd_en;
    csr_addr_t  csr_rd_addr;
    xlen_t      old_val;
    csr_write_t csr_wr;
    logic       mstatus_mie;
    xlen_t      mie;
    xlen_t      mip;

    csr_exec csr_exec_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .valid       (valid),
        .ready       (ready),
        .instbus     (instbus),
        .rs1_addr    (rs1_addr),
        .rs1_val     (rs1_val),
        .csr_rd_en   (csr_rd_en),
        .csr_rd_addr (csr_rd_addr),
        .old_val     (old_val),
        .rd_wr       (rd_wr),
        .csr_wr      (csr_wr)
    );

    csr_file csr_file_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .csr_rd_en   (csr_rd_en),
        .csr_rd_addr (csr_rd_addr),
        .old_val     (old_val),
        .csr_wr      (csr_wr),
        .mip         (mip),
        .mstatus_mie (mstatus_mie),
        .mie         (mie),
        .csr_sb      (csr_sb)
    );

    // mip writes come through the same strobe
    irq_pending irq_pending_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .irqs        (irqs),
        .mstatus_mie (mstatus_mie),
        .mie         (mie),
        .csr_wr      (csr_wr),
        .mip         (mip)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench clock and active-low reset source
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic aclk,
    output logic aresetn
);

    // 8 ns period
    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // Reset held for 16 cycles and released on a rising edge
    initial begin
        aresetn = 1'b0;
        repeat (16) @(posedge aclk);
        aresetn <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/csr_assertions.sv ====
//////////////////////////////////////////////////////////////////////
// Bound checks on CSR unit timing and legal register values
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module csr_assertions
    import csr_pkg::*;
(
    input wire                aclk,
    input wire                aresetn,
    input wire                valid,
    input wire                ready,
    input wire rd_write_t     rd_wr,
    input wire csr_sideband_t csr_sb
);

    int   fail_count = 0;
    logic accept;

    assign accept = valid && ready;

    //////////////////////////////////////////////////////////////////////
    // Handshake timing
    //////////////////////////////////////////////////////////////////////

    // Write-back is a one-cycle pulse one edge after acceptance
    writeback_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        accept |=> rd_wr.en ##1 !rd_wr.en)
    else begin
        fail_count++;
        $error("Register write-back is not a single pulse after acceptance");
    end

    // No write-back without an accepted instruction
    writeback_source: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr.en |-> $past(accept))
    else begin
        fail_count++;
        $error("Register write-back seen without an accepted instruction");
    end

    // Busy for two cycles
    ready_low: assert property (@(posedge aclk) disable iff (!aresetn)
        accept |=> !ready ##1 !ready)
    else begin
        fail_count++;
        $error("Ready came back before the instruction finished");
    end

    //////////////////////////////////////////////////////////////////////
    // Register value rules
    //////////////////////////////////////////////////////////////////////

    mepc_aligned: assert property (@(posedge aclk) disable iff (!aresetn)
        csr_sb.mepc[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("mepc has a low bit set");
    end

    // Only MIE and MPIE may be set
    mstatus_legal: assert property (@(posedge aclk) disable iff (!aresetn)
        (csr_sb.mstatus & ~MSTATUS_WMASK) == '0)
    else begin
        fail_count++;
        $error("mstatus holds a bit outside its writable fields");
    end

endmodule

bind csr_top csr_assertions csr_assertions_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .valid   (valid),
    .ready   (ready),
    .rd_wr   (rd_wr),
    .csr_sb  (csr_sb)
);

`default_nettype wire

// ==== testbench/csr_tb.sv ====
//////////////////////////////////////////////////////////////////////
// CSR unit testbench with reference model and LFSR operands
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module csr_tb
    import csr_pkg::*;
();

    logic          aclk;
    logic          aresetn;
    logic          valid;
    logic          ready;
    inst_t         instbus;
    reg_addr_t     rs1_addr;
    xlen_t         rs1_val;
    rd_write_t     rd_wr;
    irq_lines_t    irqs;
    csr_sideband_t csr_sb;

    // Integer registers and expected CSR contents
    xlen_t       regs [0:31];
    xlen_t       model [0:4095];
    logic [31:0] lfsr_state;
    time         accept_time;
    int          wait_limit = 40;

    tb_clock_gen clock_gen_i (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    csr_top csr_top_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .valid    (valid),
        .ready    (ready),
        .instbus  (instbus),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .rd_wr    (rd_wr),
        .irqs     (irqs),
        .csr_sb   (csr_sb)
    );

    // Combinational register file read
    assign rs1_val = regs[rs1_addr];

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output xlen_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic timed_out(input string what);
        $display("Timed out waiting for %s", what);
        abort_run();
    endtask

    task automatic check_value(input string what, input xlen_t got, input xlen_t exp);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic cond);
        assert (cond === 1'b1) else begin
            $display("FAILED at %0t ns: %s", $time, what);
            abort_run();
        end
    endtask

    // Keeps only the writable fields of each register
    function automatic void write_model(input csr_addr_t addr, input xlen_t val);
        case (addr)
            CSR_MSTATUS: model[addr] = val & 32'h0000_0088;
            CSR_MEPC:    model[addr] = {val[31:2], 2'b00};
            CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
            CSR_MCAUSE, CSR_MTVAL, CSR_MIP: model[addr] = val;
            default: ;
        endcase
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge aclk);
        while (!ready && n < wait_limit) begin
            @(negedge aclk);
            n++;
        end
        if (!ready) timed_out("ready");
    endtask

    task automatic set_reg(input reg_addr_t idx, input xlen_t val);
        @(posedge aclk);
        if (idx != 0) regs[idx] <= val;
    endtask

    // Runs one instruction and returns the write-back data
    task automatic exec_csr(input funct3_t f3, input csr_addr_t addr, input zimm_t src,
                            input reg_addr_t rd, output xlen_t old);
        int n;
        wait_ready();
        @(posedge aclk);
        valid   <= 1'b1;
        instbus <= {addr, src, f3, rd, 7'b1110011};
        // Acceptance edge
        @(posedge aclk);
        accept_time = $time;
        valid <= 1'b0;
        n = 0;
        @(negedge aclk);
        while (!rd_wr.en && n < wait_limit) begin
            @(negedge aclk);
            n++;
        end
        if (!rd_wr.en) timed_out("register write-back");
        check_value("write-back register index", xlen_t'(rd_wr.addr), xlen_t'(rd));
        // Swaps always write, set and clear only with a nonzero source
        check_flag("CSR write strobe against the zero-source rule",
                   csr_top_i.csr_wr.en === ((f3[1:0] == 2'b01) || (src != 0)));
        old = rd_wr.data;
    endtask

    task automatic check_op(input funct3_t f3, input csr_addr_t addr, input zimm_t src,
                            input reg_addr_t rd);
        xlen_t operand;
        xlen_t old;
        xlen_t exp_old;
        exp_old = model[addr];
        exec_csr(f3, addr, src, rd, old);
        check_value($sformatf("old value of CSR %h", addr), old, exp_old);
        // Immediate forms zero-extend
        operand = f3[2] ? {27'd0, src} : regs[src];
        case (f3)
            F3_CSRRW, F3_CSRRWI: write_model(addr, operand);
            F3_CSRRS, F3_CSRRSI: if (src != 0) write_model(addr, exp_old | operand);
            default:             if (src != 0) write_model(addr, exp_old & ~operand);
        endcase
    endtask

    // Stop as soon as a bound assertion fires
    always @(negedge aclk) begin
        if (csr_top_i.csr_assertions_i.fail_count != 0) begin
            $display("A bound assertion on the CSR unit failed");
            abort_run();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        xlen_t     val;
        xlen_t     t0;
        xlen_t     t1;
        time       tm0;
        reg_addr_t idx;
        reg_addr_t rd;
        csr_addr_t a;
        csr_addr_t wr_list [7];
        csr_addr_t set_list [2];
        int        n;

        valid      = 1'b0;
        instbus    = '0;
        irqs       = '0;
        lfsr_state = 32'hd2765031;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < 4096; i++) model[i] = '0;
        // RV32I with MXL of 1 on hart 0
        model[CSR_MISA]    = 32'h4000_0100;
        model[CSR_MHARTID] = 32'h0000_0000;
        wr_list  = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                     CSR_MEPC, CSR_MCAUSE, CSR_MTVAL};
        set_list = '{CSR_MSCRATCH, CSR_MIE};

        // After reset
        n = 0;
        @(negedge aclk);
        while (!aresetn && n < wait_limit) begin
            check_flag("ready high during reset", !ready);
            @(negedge aclk);
            n++;
        end
        if (!aresetn) timed_out("reset release");
        n = 0;
        while (!ready && n < wait_limit) begin
            check_flag("write-back strobe after reset", !rd_wr.en);
            @(negedge aclk);
            n++;
        end
        if (!ready) timed_out("ready after reset");
        check_flag("sideband zero after reset", csr_sb == '0);

        // Swap forms on random writable CSRs
        repeat (24) begin
            take_bits(3, val);
            a = wr_list[val % 7];
            take_bits(5, val);
            idx = (val[4:0] == 0) ? 5'd1 : val[4:0];
            take_bits(5, val);
            rd = val[4:0];
            take_bits(32, val);
            set_reg(idx, val);
            check_op(F3_CSRRW, a, idx, rd);
            check_op(F3_CSRRS, a, 5'd0, rd);
            take_bits(5, val);
            check_op(F3_CSRRWI, a, val[4:0], rd);
            check_op(F3_CSRRS, a, 5'd0, rd);
        end

        // Sideband copies of the swapped registers
        wait_ready();
        check_value("sideband mtvec", csr_sb.mtvec, model[CSR_MTVEC]);
        check_value("sideband mepc", csr_sb.mepc, model[CSR_MEPC]);
        check_value("sideband mstatus", csr_sb.mstatus, model[CSR_MSTATUS]);

        // Set and clear forms with and without a zero source
        repeat (4) begin
            foreach (set_list[k]) begin
                a = set_list[k];
                take_bits(5, val);
                idx = (val[4:0] == 0) ? 5'd1 : val[4:0];
                take_bits(32, val);
                set_reg(idx, val);
                check_op(F3_CSRRS, a, idx, 5'd3);
                take_bits(32, val);
                set_reg(idx, val);
                check_op(F3_CSRRC, a, idx, 5'd4);
                take_bits(5, val);
                check_op(F3_CSRRSI, a, val[4:0], 5'd5);
                take_bits(5, val);
                check_op(F3_CSRRCI, a, val[4:0], 5'd6);
                check_op(F3_CSRRS, a, 5'd0, 5'd7);
                check_op(F3_CSRRC, a, 5'd0, 5'd7);
                check_op(F3_CSRRSI, a, 5'd0, 5'd8);
                check_op(F3_CSRRCI, a, 5'd0, 5'd8);
                check_op(F3_CSRRS, a, 5'd0, 5'd9);
            end
        end

        // Constants and an unknown address
        set_reg(5'd1, 32'hFFFF_FFFF);
        check_op(F3_CSRRW, CSR_MISA, 5'd1, 5'd2);
        check_op(F3_CSRRS, CSR_MISA, 5'd0, 5'd2);
        check_op(F3_CSRRW, CSR_MHARTID, 5'd1, 5'd2);
        check_op(F3_CSRRS, CSR_MHARTID, 5'd0, 5'd2);
        check_op(F3_CSRRW, 12'h7C0, 5'd1, 5'd2);
        check_op(F3_CSRRS, 12'h7C0, 5'd0, 5'd2);

        // Time counter
        exec_csr(F3_CSRRS, CSR_TIME, 5'd0, 5'd1, t0);
        tm0 = accept_time;
        exec_csr(F3_CSRRS, CSR_TIME, 5'd0, 5'd2, t1);
        check_value("time delta", t1 - t0, xlen_t'((accept_time - tm0) / 8));
        exec_csr(F3_CSRRS, CSR_CYCLE, 5'd0, 5'd3, t1);
        check_value("cycle count", t1, t0 + xlen_t'((accept_time - tm0) / 8));
        exec_csr(F3_CSRRS, CSR_TIMEH, 5'd0, 5'd4, t1);
        check_value("upper time half", t1, 32'd0);

        // External interrupt enabled
        set_reg(5'd1, 32'h0000_0008);
        check_op(F3_CSRRW, CSR_MSTATUS, 5'd1, 5'd0);
        set_reg(5'd2, 32'h0000_0800);
        check_op(F3_CSRRW, CSR_MIE, 5'd2, 5'd0);
        @(posedge aclk);
        irqs.ext <= 1'b1;
        n = 0;
        @(negedge aclk);
        while (!csr_sb.meip && n < wait_limit) begin
            @(negedge aclk);
            n++;
        end
        if (!csr_sb.meip) timed_out("external interrupt pending bit");
        @(posedge aclk);
        irqs.ext <= 1'b0;
        for (int i = 0; i < 6; i++) begin
            @(negedge aclk);
            check_flag("meip held after the line dropped", csr_sb.meip);
        end
        model[CSR_MIP] = 32'h0000_0800;
        check_op(F3_CSRRC, CSR_MIP, 5'd2, 5'd0);
        wait_ready();
        check_flag("meip cleared by CSRRC", !csr_sb.meip);

        // Masked by mie
        check_op(F3_CSRRW, CSR_MIE, 5'd0, 5'd0);
        @(posedge aclk);
        irqs.ext <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(negedge aclk);
            check_flag("meip set with mie clear", !csr_sb.meip);
        end
        @(posedge aclk);
        irqs.ext <= 1'b0;
        wait_ready();

        if (csr_top_i.csr_assertions_i.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/csr_pkg.sv
design/csr_exec.sv
design/csr_file.sv
design/irq_pending.sv
design/csr_top.sv
testbench/tb_clock_gen.sv
testbench/csr_assertions.sv
testbench/csr_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - files:
      - design/csr_pkg.sv
      - design/csr_exec.sv
      - design/csr_file.sv
      - design/irq_pending.sv
      - design/csr_top.sv
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/csr_assertions.sv
      - testbench/csr_tb.sv
